/* alloc_pkg.sv */
package alloc_pkg;

   // Architectural register file
   localparam int ARCH_REG_W    = 5;
   localparam int NUM_ARCH_REGS = 32;

   // Reorder buffer ids, wrap at 16
   localparam int ROB_ID_W = 4;

   // Default capacities, overridden through the top level parameters
   localparam int ROB_DEPTH = 16;
   localparam int RS_DEPTH  = 4;

   typedef logic [ARCH_REG_W-1:0] t_arch_reg;
   typedef logic [ROB_ID_W-1:0]   t_rob_id;

   // Decoded micro-op as it enters the dispatch front end
   typedef struct packed {
      logic      valid;
      t_arch_reg dst;
      t_arch_reg src1;
      t_arch_reg src2;
   } t_uop;

   // Source dependency on an older in-flight producer
   typedef struct packed {
      logic    pending;
      t_rob_id robid;
   } t_src_dep;

   // Packet handed from allocation to the reservation station
   typedef struct packed {
      t_uop     uop;
      t_rob_id  robid;
      t_src_dep dep1;
      t_src_dep dep2;
   } t_disp_pkt;

endpackage

/* alloc_properties.sv */
`timescale 1ns/100ps

module alloc_props #(
   parameter int capacity = alloc_pkg::RS_DEPTH + 1
) (
   input logic                 clk,
   input logic                 rst,
   input logic                 uop_ready,
   input logic                 issue_valid,
   input alloc_pkg::t_rob_id   issue_robid,
   input alloc_pkg::t_arch_reg issue_dst,
   input alloc_pkg::t_src_dep  issue_dep1,
   input alloc_pkg::t_src_dep  issue_dep2,
   input logic                 exp_valid,
   input alloc_pkg::t_disp_pkt exp_pkt,
   input int                   exp_cnt
);
   import alloc_pkg::*;

   int fail_cnt = 0;

   reset_state: assert property (@(posedge clk) $fell(rst) |-> uop_ready && !issue_valid)
      else begin
         fail_cnt++;
         $error("[ERROR] reset_state expected ready 1 valid 0 actual ready %0b valid %0b",
            $sampled(uop_ready), $sampled(issue_valid));
      end

   issue_expected: assert property (@(posedge clk) disable iff (rst) issue_valid |-> exp_valid)
      else begin
         fail_cnt++;
         $error("issue_valid high while no accepted micro-op is outstanding");
      end

   // Robid and destination in acceptance order
   issue_order: assert property (@(posedge clk) disable iff (rst)
      issue_valid && exp_valid |-> issue_robid == exp_pkt.robid && issue_dst == exp_pkt.uop.dst)
      else begin
         fail_cnt++;
         $error("[ERROR] issue_order expected robid %0d dst %0d actual robid %0d dst %0d",
            $sampled(exp_pkt.robid), $sampled(exp_pkt.uop.dst),
            $sampled(issue_robid), $sampled(issue_dst));
      end

   // Producer id only counts while the source is pending
   issue_deps: assert property (@(posedge clk) disable iff (rst)
      issue_valid && exp_valid |->
         issue_dep1.pending == exp_pkt.dep1.pending &&
         (!exp_pkt.dep1.pending || issue_dep1.robid == exp_pkt.dep1.robid) &&
         issue_dep2.pending == exp_pkt.dep2.pending &&
         (!exp_pkt.dep2.pending || issue_dep2.robid == exp_pkt.dep2.robid))
      else begin
         fail_cnt++;
         $error("[ERROR] issue_deps expected %0h %0h actual %0h %0h",
            $sampled(exp_pkt.dep1), $sampled(exp_pkt.dep2),
            $sampled(issue_dep1), $sampled(issue_dep2));
      end

   hold_capacity: assert property (@(posedge clk) disable iff (rst) exp_cnt <= capacity)
      else begin
         fail_cnt++;
         $error("[ERROR] hold_capacity expected at most %0d in flight actual %0d",
            capacity, $sampled(exp_cnt));
      end

endmodule

/* alloc_stage.sv */
`timescale 1ns/100ps

module alloc_stage (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  logic                uop_valid,
   input  alloc_pkg::t_uop     uop,
   input  alloc_pkg::t_src_dep dep1,
   input  alloc_pkg::t_src_dep dep2,
   input  alloc_pkg::t_rob_id  next_robid,
   input  logic                rob_ready,
   output logic                uop_ready,
   output logic                alloc_fire,
   disp_if.alloc_mp            disp
);
   import alloc_pkg::*;

   t_disp_pkt pkt_d;
   t_disp_pkt pkt_q;
   logic      valid_q;
   logic      stall;

   // Queue back-pressure or no free reorder entry
   assign stall      = disp.stall | ~rob_ready;
   assign uop_ready  = ~stall;
   assign alloc_fire = uop_valid & uop_ready;

   always_comb begin
      pkt_d           = '0;
      pkt_d.uop       = uop;
      pkt_d.uop.valid = alloc_fire;
      pkt_d.robid     = next_robid;
      pkt_d.dep1      = dep1;
      pkt_d.dep2      = dep2;
   end

   // Register holds while the queue refuses the packet
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         valid_q <= 1'b0;
      end else if (!disp.stall) begin
         valid_q <= alloc_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (!disp.stall) begin
         pkt_q <= pkt_d;
      end
   end

   assign disp.valid = valid_q;
   assign disp.pkt   = pkt_q;

endmodule

/* alloc_top.sv */
`timescale 1ns/100ps

module alloc_top #(
   parameter int rob_depth = alloc_pkg::ROB_DEPTH,
   parameter int rs_depth  = alloc_pkg::RS_DEPTH
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 flush,
   input  logic                 uop_valid,
   input  alloc_pkg::t_arch_reg uop_dst,
   input  alloc_pkg::t_arch_reg uop_src1,
   input  alloc_pkg::t_arch_reg uop_src2,
   output logic                 uop_ready,
   input  logic                 issue_hold,
   output logic                 issue_valid,
   output alloc_pkg::t_rob_id   issue_robid,
   output alloc_pkg::t_arch_reg issue_dst,
   output alloc_pkg::t_src_dep  issue_dep1,
   output alloc_pkg::t_src_dep  issue_dep2
);
   import alloc_pkg::*;

   t_uop      uop;
   t_src_dep  dep1;
   t_src_dep  dep2;
   t_rob_id   next_robid;
   logic      rob_ready;
   logic      alloc_fire;
   logic      head_valid;
   t_disp_pkt head_pkt;
   logic      pop;
   logic      retire_valid;
   t_rob_id   retire_robid;
   t_arch_reg retire_dst;
   logic      issue_clr;

   disp_if disp ();

   assign uop.valid = uop_valid;
   assign uop.dst   = uop_dst;
   assign uop.src1  = uop_src1;
   assign uop.src2  = uop_src2;

   // Flush also drops a retirement still in the issue register
   assign issue_clr = rst | flush;

   rename_map #(
      .rob_depth (rob_depth)
   ) u_rename (
      .clk          (clk),
      .rst          (rst),
      .flush        (flush),
      .alloc_fire   (alloc_fire),
      .dst          (uop_dst),
      .src1         (uop_src1),
      .src2         (uop_src2),
      .dep1         (dep1),
      .dep2         (dep2),
      .next_robid   (next_robid),
      .rob_ready    (rob_ready),
      .retire_valid (retire_valid),
      .retire_robid (retire_robid),
      .retire_dst   (retire_dst)
   );

   alloc_stage u_alloc (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .uop_valid  (uop_valid),
      .uop        (uop),
      .dep1       (dep1),
      .dep2       (dep2),
      .next_robid (next_robid),
      .rob_ready  (rob_ready),
      .uop_ready  (uop_ready),
      .alloc_fire (alloc_fire),
      .disp       (disp.alloc_mp)
   );

   rsv_station #(
      .rs_depth (rs_depth)
   ) u_rs (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .disp       (disp.rs_mp),
      .head_valid (head_valid),
      .head_pkt   (head_pkt),
      .pop        (pop)
   );

   issue_select u_issue (
      .clk          (clk),
      .rst          (issue_clr),
      .head_valid   (head_valid),
      .head_pkt     (head_pkt),
      .issue_hold   (issue_hold),
      .pop          (pop),
      .issue_valid  (issue_valid),
      .issue_robid  (issue_robid),
      .issue_dst    (issue_dst),
      .issue_dep1   (issue_dep1),
      .issue_dep2   (issue_dep2),
      .retire_valid (retire_valid),
      .retire_robid (retire_robid),
      .retire_dst   (retire_dst)
   );

endmodule

/* disp_if.sv */
`timescale 1ns/100ps

// Dispatch handshake between allocation and the reservation station.
// A packet moves on any rising edge with valid high and stall low.
interface disp_if;
   import alloc_pkg::*;

   logic      valid;
   t_disp_pkt pkt;
   logic      stall;

   // Producer side, allocation stage
   modport alloc_mp (
      output valid,
      output pkt,
      input  stall
   );

   // Consumer side, reservation station queue
   modport rs_mp (
      input  valid,
      input  pkt,
      output stall
   );

endinterface

/* issue_select.sv */
`timescale 1ns/100ps

module issue_select (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 head_valid,
   input  alloc_pkg::t_disp_pkt head_pkt,
   input  logic                 issue_hold,
   output logic                 pop,
   output logic                 issue_valid,
   output alloc_pkg::t_rob_id   issue_robid,
   output alloc_pkg::t_arch_reg issue_dst,
   output alloc_pkg::t_src_dep  issue_dep1,
   output alloc_pkg::t_src_dep  issue_dep2,
   output logic                 retire_valid,
   output alloc_pkg::t_rob_id   retire_robid,
   output alloc_pkg::t_arch_reg retire_dst
);
   import alloc_pkg::*;

   logic      ret_valid_q;
   t_rob_id   ret_robid_q;
   t_arch_reg ret_dst_q;

   // In-order issue straight from the queue head
   assign pop         = head_valid & ~issue_hold;
   assign issue_valid = pop;
   assign issue_robid = head_pkt.robid;
   assign issue_dst   = head_pkt.uop.dst;
   assign issue_dep1  = head_pkt.dep1;
   assign issue_dep2  = head_pkt.dep2;

   // Retirement lands one edge after issue, keeps the lookup path acyclic
   always_ff @(posedge clk) begin
      if (rst) begin
         ret_valid_q <= 1'b0;
      end else begin
         ret_valid_q <= pop;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         ret_robid_q <= head_pkt.robid;
         ret_dst_q   <= head_pkt.uop.dst;
      end
   end

   assign retire_valid = ret_valid_q;
   assign retire_robid = ret_robid_q;
   assign retire_dst   = ret_dst_q;

endmodule

/* rename_map.sv */
`timescale 1ns/100ps

module rename_map #(
   parameter int rob_depth = alloc_pkg::ROB_DEPTH
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  logic                alloc_fire,
   input  alloc_pkg::t_arch_reg dst,
   input  alloc_pkg::t_arch_reg src1,
   input  alloc_pkg::t_arch_reg src2,
   output alloc_pkg::t_src_dep  dep1,
   output alloc_pkg::t_src_dep  dep2,
   output alloc_pkg::t_rob_id   next_robid,
   output logic                rob_ready,
   input  logic                retire_valid,
   input  alloc_pkg::t_rob_id   retire_robid,
   input  alloc_pkg::t_arch_reg retire_dst
);
   import alloc_pkg::*;

   localparam int CNT_W = $clog2(rob_depth + 1);

   // Pending table, one bit and a producer id per architectural register
   logic [NUM_ARCH_REGS-1:0] pend_q;
   t_rob_id                  prod_q [NUM_ARCH_REGS];

   t_rob_id          robid_q;
   logic [CNT_W-1:0] count_q;
   logic             retire_hit;

   // Lookup sees the table before this cycle's update
   assign dep1.pending = pend_q[src1];
   assign dep1.robid   = prod_q[src1];
   assign dep2.pending = pend_q[src2];
   assign dep2.robid   = prod_q[src2];

   assign next_robid = robid_q;
   assign rob_ready  = (count_q < CNT_W'(rob_depth));

   // Only the newest writer of a register may clear its mark
   assign retire_hit = retire_valid && (prod_q[retire_dst] == retire_robid);

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         pend_q <= '0;
      end else begin
         if (retire_hit) begin
            pend_q[retire_dst] <= 1'b0;
         end
         // A new writer overrides a retire to the same register
         if (alloc_fire && (dst != '0)) begin
            pend_q[dst] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alloc_fire && (dst != '0)) begin
         prod_q[dst] <= robid_q;
      end
   end

   // Robid counter wraps with its width
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         robid_q <= '0;
      end else if (alloc_fire) begin
         robid_q <= robid_q + 1'b1;
      end
   end

   // Accept and retire in the same cycle cancel out
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + CNT_W'(alloc_fire) - CNT_W'(retire_valid);
      end
   end

endmodule

/* rsv_station.sv */
`timescale 1ns/100ps

module rsv_station #(
   parameter int rs_depth = alloc_pkg::RS_DEPTH
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 flush,
   disp_if.rs_mp                disp,
   output logic                 head_valid,
   output alloc_pkg::t_disp_pkt head_pkt,
   input  logic                 pop
);
   import alloc_pkg::*;

   localparam int PTR_W = (rs_depth > 1) ? $clog2(rs_depth) : 1;
   localparam int CNT_W = $clog2(rs_depth + 1);

   t_disp_pkt        mem [rs_depth];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count_q;
   logic             full;
   logic             push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(rs_depth - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign full   = (count_q == CNT_W'(rs_depth));
   assign push   = disp.valid & ~disp.stall;
   assign do_pop = pop & head_valid;

   // Full queue refuses, even when the head leaves this cycle
   assign disp.stall = full;

   assign head_valid = (count_q != '0);
   assign head_pkt   = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= disp.pkt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count_q <= count_q + CNT_W'(push) - CNT_W'(do_pop);
      end
   end

endmodule

/* tb.f */
alloc_pkg.sv
disp_if.sv
rename_map.sv
alloc_stage.sv
rsv_station.sv
issue_select.sv
alloc_top.sv
alloc_properties.sv
tb_alloc.sv

/* tb_alloc.sv */
`timescale 1ns/100ps

module tb_alloc;
   import alloc_pkg::*;

   localparam int n_rand         = 300;
   // Four cycles per random micro-op at worst, plus the directed phases
   localparam int timeout_cycles = 4 * n_rand + 800;
   localparam int capacity       = RS_DEPTH + 1;

   logic      clk;
   logic      rst;
   logic      flush;
   logic      uop_valid;
   t_arch_reg uop_dst;
   t_arch_reg uop_src1;
   t_arch_reg uop_src2;
   logic      uop_ready;
   logic      issue_hold;
   logic      issue_valid;
   t_rob_id   issue_robid;
   t_arch_reg issue_dst;
   t_src_dep  issue_dep1;
   t_src_dep  issue_dep2;

   // Reference model and the expected head of the issue stream
   t_disp_pkt   exp_q [$];
   logic [31:0] m_pend;
   t_rob_id     m_prod [32];
   t_rob_id     m_next;
   logic        m_ret_v;
   t_disp_pkt   m_ret;
   logic        exp_valid = 1'b0;
   t_disp_pkt   exp_pkt;
   int          exp_cnt = 0;

   int          errors = 0;
   int          cycles = 0;
   logic        hold_random = 1'b1;
   int unsigned seed = 8165;
   int unsigned hold_seed = 8165;
   int          hold_accepts;

   alloc_top DUT (.*);

   bind alloc_top alloc_props u_props (.*, .exp_valid(tb_alloc.exp_valid),
      .exp_pkt(tb_alloc.exp_pkt), .exp_cnt(tb_alloc.exp_cnt));

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Random hold about one cycle in four
   always @(negedge clk) begin
      if (hold_random) begin
         hold_seed  = lcg_next(hold_seed);
         issue_hold = (hold_seed[21:20] == 2'b00);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   // Advanced on every rising edge from the values before the edge
   always @(posedge clk) begin
      t_disp_pkt p;
      logic      acc;
      acc = uop_valid && uop_ready;
      if (rst || flush) begin
         exp_q.delete();
         m_pend  = '0;
         m_next  = '0;
         m_ret_v = 1'b0;
         foreach (m_prod[r])
            m_prod[r] = '0;
      end else begin
         // Lookup sees the table before this edge's retire and accept
         p = '{uop: '{1'b1, uop_dst, uop_src1, uop_src2}, robid: m_next,
               dep1: '{m_pend[uop_src1], m_prod[uop_src1]},
               dep2: '{m_pend[uop_src2], m_prod[uop_src2]}};
         // Retire lands one edge after issue, newest writer only
         if (m_ret_v && m_ret.uop.dst != '0 && m_prod[m_ret.uop.dst] == m_ret.robid) begin
            m_pend[m_ret.uop.dst] = 1'b0;
         end
         m_ret_v = 1'b0;
         if (issue_valid && exp_q.size() != 0) begin
            m_ret   = exp_q.pop_front();
            m_ret_v = 1'b1;
         end
         if (acc) begin
            exp_q.push_back(p);
            if (uop_dst != '0) begin
               m_pend[uop_dst] = 1'b1;
               m_prod[uop_dst] = m_next;
            end
            m_next = m_next + 1'b1;
         end
      end
      exp_valid = (exp_q.size() != 0);
      if (exp_valid) begin
         exp_pkt = exp_q[0];
      end
      exp_cnt = exp_q.size();
   end

   task automatic send_uop(input t_arch_reg d, input t_arch_reg s1, input t_arch_reg s2);
      uop_valid = 1'b1;
      uop_dst   = d;
      uop_src1  = s1;
      uop_src2  = s2;
      while (!uop_ready) begin
         @(negedge clk);
      end
      @(negedge clk);
      uop_valid = 1'b0;
   endtask

   // Registers 0 to 7 so that sources often hit a recent writer
   task automatic send_random();
      seed = lcg_next(seed);
      send_uop({2'b00, seed[18:16]}, {2'b00, seed[22:20]}, {2'b00, seed[26:24]});
   endtask

   task automatic drain();
      for (int k = 0; k < 100 && exp_q.size() != 0; k++) begin
         @(negedge clk);
      end
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d accepted micro-ops were never issued", exp_q.size());
      end
   endtask

   initial begin
      rst        = 1'b1;
      flush      = 1'b0;
      uop_valid  = 1'b0;
      uop_dst    = '0;
      uop_src1   = '0;
      uop_src2   = '0;
      issue_hold = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < n_rand; i++) begin
         send_random();
         if (seed[30:29] == 2'b00) begin
            @(negedge clk);
         end
      end
      hold_random = 1'b0;
      issue_hold  = 1'b0;
      drain();

      // Fill the stage and the queue behind a held issue port
      issue_hold   = 1'b1;
      hold_accepts = 0;
      while (uop_ready && hold_accepts < 2 * capacity) begin
         send_random();
         hold_accepts++;
      end
      assert (hold_accepts <= capacity) else begin
         errors++;
         $display("[ERROR] hold_accepts expected at most %0d actual %0d", capacity, hold_accepts);
      end
      issue_hold = 1'b0;
      drain();

      // Flush with micro-ops in flight, numbering restarts at 0
      issue_hold = 1'b1;
      repeat (3) send_random();
      flush = 1'b1;
      @(negedge clk);
      flush      = 1'b0;
      issue_hold = 1'b0;
      repeat (4) @(negedge clk);
      repeat (4) send_random();
      drain();

      $display("Closing report: %0d assertion errors, %0d sequence errors",
         DUT.u_props.fail_cnt, errors);
      if (errors == 0 && DUT.u_props.fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
